// File: pt2272_decoder.f
+incdir+.
pt2272_pkg.sv
pt2272_symbol_detector.sv
pt2272_frame_assembler.sv
pt2272_frame_checker.sv
pt2272_decoder.sv
tb_pt2272_decoder.sv

// File: Bender.yml
package:
  name: pt2272_decoder

sources:
  - include_dirs:
      - .
    files:
      - pt2272_pkg.sv
      - pt2272_symbol_detector.sv
      - pt2272_frame_assembler.sv
      - pt2272_frame_checker.sv
      - pt2272_decoder.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_pt2272_decoder.sv

// File: tb_pt2272_decoder.sv
`include "pt2272_macros.svh"

module tb_pt2272_decoder;
    timeunit 1ns;
    timeprecision 1ns;
    import pt2272_pkg::*;

    localparam int SYNC_LOW = `PT_SYNC_MIN + 64;   // Gap well past the sync threshold
    localparam int BAD_W    = 28;                  // Between short and long windows

    // First listed trit is sent first
    localparam pt_addr_t ADDR_HOME = '{TRIT_ONE, TRIT_ZERO, TRIT_ONE, TRIT_ONE,
                                       TRIT_ZERO, TRIT_ZERO, TRIT_ONE, TRIT_ZERO};
    localparam pt_addr_t ADDR_ONE_OFF = '{TRIT_ZERO, TRIT_ZERO, TRIT_ONE, TRIT_ONE,
                                          TRIT_ZERO, TRIT_ZERO, TRIT_ONE, TRIT_ZERO};
    localparam pt_addr_t ADDR_FLT_OFF = '{TRIT_ONE, TRIT_ZERO, TRIT_ONE, TRIT_ONE,
                                          TRIT_FLOAT, TRIT_ZERO, TRIT_ONE, TRIT_ZERO};
    localparam pt_addr_t ADDR_FLOATS = '{TRIT_ONE, TRIT_FLOAT, TRIT_ONE, TRIT_ONE,
                                         TRIT_ZERO, TRIT_FLOAT, TRIT_ONE, TRIT_ZERO};
    localparam pt_data_t DATA_A = '{TRIT_ONE, TRIT_ZERO, TRIT_ONE, TRIT_ONE};    // 4'hb
    localparam pt_data_t DATA_B = '{TRIT_ZERO, TRIT_ONE, TRIT_ONE, TRIT_ZERO};   // 4'h6
    localparam pt_data_t DATA_C = '{TRIT_ONE, TRIT_ONE, TRIT_ZERO, TRIT_ZERO};   // 4'hc
    localparam pt_data_t DATA_F = '{TRIT_ONE, TRIT_FLOAT, TRIT_ZERO, TRIT_ONE};  // Float data

    logic                      clk;
    logic                      reset;
    logic                      cod_i;
    pt_addr_t                  address_i;
    logic [`PT_DATA_TRITS-1:0] data_o;
    logic                      valid_o;

    integer seed = 32'h5fbb1d28;
    bit     use_rand;       // Random in-range widths instead of nominal
    int     pulse_cnt;      // valid_o pulses since last clear
    int     err_cnt;
    int     chk_cnt;

    pt2272_decoder i_dut (
        .clk       (clk),
        .reset     (reset),
        .cod_i     (cod_i),
        .address_i (address_i),
        .data_o    (data_o),
        .valid_o   (valid_o)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        if (valid_o) pulse_cnt = pulse_cnt + 1;    // Value from the previous cycle
    end

    function automatic int pick_width(input int lo, input int hi, input int nom);
        if (!use_rand) return nom;
        return lo + int'($unsigned($random(seed)) % (hi - lo + 1));
    endfunction

    task automatic hold_line(input logic level, input int cycles);
        cod_i = level;
        repeat (cycles) begin
            @(posedge clk);
            #5;     // Drive away from the edge
        end
    endtask

    task automatic send_half(input int hi_w, input int lo_w);
        hold_line(1'b1, hi_w);
        hold_line(1'b0, lo_w);
    endtask

    // 0 is short high then long low, 1 the reverse
    task automatic send_bit_half(input logic b);
        int s_w;
        int l_w;
        s_w = pick_width(`PT_SHORT_MIN, `PT_SHORT_MAX, 16);
        l_w = pick_width(`PT_LONG_MIN, `PT_LONG_MAX, 48);
        if (b) send_half(l_w, s_w);
        else send_half(s_w, l_w);
    endtask

    task automatic send_trit(input pt_trit_e t);
        send_bit_half(t == TRIT_ONE);       // Float starts with a 0 half
        send_bit_half(t != TRIT_ZERO);
    endtask

    task automatic send_sync();
        send_half(pick_width(`PT_SHORT_MIN, `PT_SHORT_MAX, 16), SYNC_LOW);
    endtask

    // Sends the first n_trits trits, a bad width at trit bad_at, then sync
    task automatic send_frame(input pt_addr_t addr, input pt_data_t data,
                              input int n_trits, input int bad_at);
        pt_trit_e seq [`PT_FRAME_TRITS];
        for (int i = 0; i < `PT_ADDR_TRITS; i++)
            seq[i] = addr[`PT_ADDR_TRITS-1-i];
        for (int i = 0; i < `PT_DATA_TRITS; i++)
            seq[`PT_ADDR_TRITS+i] = data[`PT_DATA_TRITS-1-i];
        for (int i = 0; i < n_trits; i++) begin
            if (i == bad_at) begin
                send_half(BAD_W, 48);   // High fits no window
                send_bit_half(1'b0);
            end else begin
                send_trit(seq[i]);
            end
        end
        send_sync();
    endtask

    task automatic apply_reset();
        reset = 1'b1;
        hold_line(1'b0, 2);
        reset = 1'b0;
        pulse_cnt = 0;
    endtask

    task automatic wait_valid(input int max_cycles);
        int n;
        n = 0;
        while ((pulse_cnt == 0) && (n < max_cycles)) begin
            hold_line(1'b0, 1);
            n++;
        end
        if (pulse_cnt == 0) begin
            $display("ERROR: timeout waiting for valid_o after %0d cycles", max_cycles);
            err_cnt++;
        end
    endtask

    task automatic check_data(input logic [`PT_DATA_TRITS-1:0] exp);
        chk_cnt++;
        if (data_o !== exp) begin
            $display("FAIL data_o: got %h expected %h", data_o, exp);
            err_cnt++;
        end
    endtask

    // Idle for a window, then compare all pulses since the last clear
    task automatic check_valid_count(input int window, input int exp);
        hold_line(1'b0, window);
        chk_cnt++;
        if (pulse_cnt != exp) begin
            $display("FAIL valid_o pulses: got %h expected %h", pulse_cnt, exp);
            err_cnt++;
        end
    endtask

    task automatic test_reset_and_pair();
        apply_reset();
        check_valid_count(20, 0);
        check_data(4'h0);
        repeat (2) send_frame(ADDR_HOME, DATA_A, 12, -1);
        wait_valid(400);
        check_valid_count(100, 1);
        check_data(4'hb);           // First data trit lands in bit 3
        use_rand = 1'b1;
        pulse_cnt = 0;
        repeat (2) send_frame(ADDR_HOME, DATA_B, 12, -1);
        wait_valid(400);
        check_valid_count(100, 1);
        check_data(4'h6);
        use_rand = 1'b0;
    endtask

    task automatic test_single_frame();
        apply_reset();
        send_frame(ADDR_HOME, DATA_A, 12, -1);
        check_valid_count(600, 0);
    endtask

    task automatic test_address_match();
        apply_reset();
        repeat (2) send_frame(ADDR_ONE_OFF, DATA_A, 12, -1);
        repeat (2) send_frame(ADDR_FLT_OFF, DATA_A, 12, -1);    // Zero versus float
        check_valid_count(100, 0);
        address_i = ADDR_FLOATS;
        repeat (2) send_frame(ADDR_FLOATS, DATA_C, 12, -1);
        wait_valid(400);
        check_valid_count(100, 1);
        check_data(4'hc);
        address_i = ADDR_HOME;
    endtask

    task automatic test_float_data();
        apply_reset();
        send_frame(ADDR_HOME, DATA_A, 12, -1);
        send_frame(ADDR_HOME, DATA_F, 12, -1);     // Clears the candidate
        send_frame(ADDR_HOME, DATA_A, 12, -1);
        check_valid_count(100, 0);
        send_frame(ADDR_HOME, DATA_A, 12, -1);
        wait_valid(400);
        check_valid_count(100, 1);
        check_data(4'hb);
    endtask

    task automatic test_dropped_frames();
        apply_reset();
        send_frame(ADDR_HOME, DATA_A, 12, -1);
        send_frame(ADDR_HOME, DATA_A, 12, 5);      // Bad width mid frame
        send_frame(ADDR_HOME, DATA_A, 12, -1);
        wait_valid(400);
        check_valid_count(100, 1);
        check_data(4'hb);
        pulse_cnt = 0;
        send_frame(ADDR_HOME, DATA_B, 12, -1);
        send_frame(ADDR_HOME, DATA_B, 11, -1);     // One trit short
        send_frame(ADDR_HOME, DATA_B, 12, -1);
        wait_valid(400);
        check_valid_count(100, 1);
        check_data(4'h6);
    endtask

    task automatic test_replace_and_hold();
        apply_reset();
        send_frame(ADDR_HOME, DATA_A, 12, -1);
        send_frame(ADDR_HOME, DATA_B, 12, -1);     // B replaces A
        check_valid_count(100, 0);                 // Two different frames are no pair
        send_frame(ADDR_HOME, DATA_B, 12, -1);
        wait_valid(400);
        check_valid_count(100, 1);
        check_data(4'h6);
        send_frame(ADDR_HOME, DATA_F, 12, -1);
        send_frame(ADDR_ONE_OFF, DATA_A, 12, -1);
        check_valid_count(200, 1);
        check_data(4'h6);
    endtask

    initial begin
        clk       = 1'b0;
        reset     = 1'b1;
        cod_i     = 1'b0;
        address_i = ADDR_HOME;
        use_rand  = 1'b0;
        pulse_cnt = 0;
        err_cnt   = 0;
        chk_cnt   = 0;
        test_reset_and_pair();
        test_single_frame();
        test_address_match();
        test_float_data();
        test_dropped_frames();
        test_replace_and_hold();
        $display("checks: %0d, errors: %0d", chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// File: pt2272_decoder.sv
`include "pt2272_macros.svh"

module pt2272_decoder (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      cod_i,        // From RF or IR receiver
    input  pt2272_pkg::pt_addr_t      address_i,    // Address pins of this decoder
    output logic [`PT_DATA_TRITS-1:0] data_o,       // Latched data
    output logic                      valid_o       // Pulse per confirmed frame
);
    import pt2272_pkg::*;

    pt_symbol_t sym;    // Detector to assembler
    pt_frame_t  frame;  // Assembler to checker

    // Line pulses to symbols
    pt2272_symbol_detector i_symbol_detector (
        .clk   (clk),
        .reset (reset),
        .cod_i (cod_i),
        .sym_o (sym)
    );

    // Symbols to 12-trit words
    pt2272_frame_assembler i_frame_assembler (
        .clk     (clk),
        .reset   (reset),
        .sym_i   (sym),
        .frame_o (frame)
    );

    // Words to confirmed data
    pt2272_frame_checker i_frame_checker (
        .clk       (clk),
        .reset     (reset),
        .frame_i   (frame),
        .address_i (address_i),
        .data_o    (data_o),
        .valid_o   (valid_o)
    );

endmodule

// File: pt2272_frame_checker.sv
`include "pt2272_macros.svh"

module pt2272_frame_checker (
    input  logic                          clk,
    input  logic                          reset,
    input  pt2272_pkg::pt_frame_t         frame_i,
    input  pt2272_pkg::pt_addr_t          address_i,    // Local address, quasi-static
    output logic [`PT_DATA_TRITS-1:0]     data_o,
    output logic                          valid_o
);
    import pt2272_pkg::*;

    pt_frame_u                  cand_q;     // Last qualifying frame
    logic                       cand_vld;
    logic                       addr_ok;
    logic                       data_ok;
    logic                       qualify;
    logic                       same;
    logic [`PT_DATA_TRITS-1:0]  data_bits;

    // Address trit by trit, float only matches float
    always_comb begin
        addr_ok = 1'b1;
        for (int i = 0; i < `PT_ADDR_TRITS; i++) begin
            if (frame_i.word.fields.addr[i] != address_i[i]) addr_ok = 1'b0;
        end
    end

    // Data trits must be plain 0 or 1
    always_comb begin
        data_ok = 1'b1;
        for (int i = 0; i < `PT_DATA_TRITS; i++) begin
            data_bits[i] = (frame_i.word.fields.data[i] == TRIT_ONE);  // Bit 3 is first trit
            if ((frame_i.word.fields.data[i] != TRIT_ZERO) &&
                (frame_i.word.fields.data[i] != TRIT_ONE))
                data_ok = 1'b0;
        end
    end

    assign qualify = addr_ok & data_ok;
    assign same    = cand_vld && (frame_i.word == cand_q);

    always_ff @(posedge clk) begin
        if (frame_i.valid && qualify && !same) cand_q <= frame_i.word;  // New candidate
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cand_vld <= 1'b0;
            valid_o  <= 1'b0;
            data_o   <= '0;
        end else begin
            valid_o <= 1'b0;
            if (frame_i.valid) begin
                if (!qualify) begin
                    cand_vld <= 1'b0;       // Bad frame breaks the pair
                end else if (same) begin
                    cand_vld <= 1'b0;       // Confirmed, start over
                    valid_o  <= 1'b1;
                    data_o   <= data_bits;  // Held until next confirmation
                end else begin
                    cand_vld <= 1'b1;
                end
            end
        end
    end

endmodule

// File: pt2272_frame_assembler.sv
`include "pt2272_macros.svh"

module pt2272_frame_assembler (
    input  logic                   clk,
    input  logic                   reset,
    input  pt2272_pkg::pt_symbol_t sym_i,
    output pt2272_pkg::pt_frame_t  frame_o
);
    import pt2272_pkg::*;

    localparam int CNT_W = $clog2(`PT_FRAME_TRITS + 2);
    localparam logic [CNT_W-1:0] FULL_CNT = `PT_FRAME_TRITS;
    localparam logic [CNT_W-1:0] OVER_CNT = `PT_FRAME_TRITS + 1;  // Overlong marker

    pt_frame_u        shift_q;      // Trits in arrival order, oldest on top
    pt_frame_u        word_q;       // Released word
    logic             word_vld;
    logic [CNT_W-1:0] trit_cnt;
    pt_trit_e         trit_in;
    logic             is_trit;

    // Symbol kind to trit code
    always_comb begin
        trit_in = TRIT_ZERO;
        is_trit = 1'b0;
        case (sym_i.kind)
            SYM_ZERO:  begin trit_in = TRIT_ZERO;  is_trit = 1'b1; end
            SYM_ONE:   begin trit_in = TRIT_ONE;   is_trit = 1'b1; end
            SYM_FLOAT: begin trit_in = TRIT_FLOAT; is_trit = 1'b1; end
            default:   is_trit = 1'b0;              // Sync or bad
        endcase
    end

    always_ff @(posedge clk) begin
        if (sym_i.valid && is_trit)
            shift_q.trits <= {shift_q.trits[`PT_FRAME_TRITS-2:0], trit_in};
        if (sym_i.valid && (sym_i.kind == SYM_SYNC))
            word_q <= shift_q;      // Capture at sync, qualified by word_vld
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            trit_cnt <= '0;
            word_vld <= 1'b0;
        end else begin
            word_vld <= 1'b0;
            if (sym_i.valid) begin
                if (is_trit) begin
                    if (trit_cnt != OVER_CNT) trit_cnt <= trit_cnt + 1'b1;  // Stick when too long
                end else begin
                    trit_cnt <= '0;     // Bad or sync restarts the frame
                    if ((sym_i.kind == SYM_SYNC) && (trit_cnt == FULL_CNT))
                        word_vld <= 1'b1;
                end
            end
        end
    end

    assign frame_o = '{valid: word_vld, word: word_q};

endmodule

// File: pt2272_symbol_detector.sv
`include "pt2272_macros.svh"

module pt2272_symbol_detector (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   cod_i,     // Async serial line
    output pt2272_pkg::pt_symbol_t sym_o
);
    import pt2272_pkg::*;

    localparam logic [`PT_CNT_W-1:0] CNT_MAX  = '1;
    localparam logic [`PT_CNT_W-1:0] SYNC_CNT = `PT_SYNC_MIN;

    logic                 cod_q1;       // Synchronizer stage 1
    logic                 cod_q2;       // Synchronizer stage 2
    logic                 cod_q3;       // Previous synced level for edges
    logic                 rise;
    logic                 fall;
    logic [`PT_CNT_W-1:0] hi_cnt;       // Cycles high so far
    logic [`PT_CNT_W-1:0] lo_cnt;       // Cycles low so far, sticks at SYNC_CNT
    logic [`PT_CNT_W-1:0] high_w;       // Last complete high width
    logic                 have_high;    // A high has been measured since reset
    logic                 half_pend;    // First half of a trit is waiting
    logic                 half_val;     // Its value, 1 = long high
    logic                 half_ok;
    logic                 half_bit;
    logic                 sync_hit;
    logic                 pend_d;
    logic                 val_d;
    pt_symbol_t           sym_d;

    function automatic logic is_short(logic [`PT_CNT_W-1:0] w);
        return (w >= `PT_SHORT_MIN) && (w <= `PT_SHORT_MAX);
    endfunction

    function automatic logic is_long(logic [`PT_CNT_W-1:0] w);
        return (w >= `PT_LONG_MIN) && (w <= `PT_LONG_MAX);
    endfunction

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cod_q1 <= 1'b0;
            cod_q2 <= 1'b0;
            cod_q3 <= 1'b0;
        end else begin
            cod_q1 <= cod_i;
            cod_q2 <= cod_q1;
            cod_q3 <= cod_q2;
        end
    end

    assign rise = cod_q2 & ~cod_q3;
    assign fall = ~cod_q2 & cod_q3;

    // Counter reads the full width of a level in the edge cycle that ends it
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            hi_cnt <= '0;
            lo_cnt <= '0;
        end else if (cod_q2) begin
            if (rise) hi_cnt <= 1;
            else if (hi_cnt != CNT_MAX) hi_cnt <= hi_cnt + 1'b1;   // Saturate on stuck high
        end else begin
            if (fall) lo_cnt <= 1;
            else if (lo_cnt != SYNC_CNT) lo_cnt <= lo_cnt + 1'b1;  // Hold once sync seen
        end
    end

    always_ff @(posedge clk) begin
        if (fall) high_w <= hi_cnt;     // Latch high width at falling edge
    end

    // Half decode: short high + long low is 0, long high + short low is 1
    assign half_ok  = (is_short(high_w) && is_long(lo_cnt)) ||
                      (is_long(high_w) && is_short(lo_cnt));
    assign half_bit = is_long(high_w);
    assign sync_hit = ~cod_q2 & ~cod_q3 & (lo_cnt == SYNC_CNT - 1'b1);  // Reaches threshold now

    always_comb begin
        sym_d.valid = 1'b0;
        sym_d.kind  = SYM_BAD;
        pend_d      = half_pend;
        val_d       = half_val;
        if (rise && have_high && (lo_cnt != SYNC_CNT)) begin    // Sync gap already handled
            if (!half_ok) begin
                sym_d.valid = 1'b1;     // Bad width, drop the half too
                pend_d      = 1'b0;
            end else if (!half_pend) begin
                pend_d = 1'b1;          // Keep first half
                val_d  = half_bit;
            end else begin
                sym_d.valid = 1'b1;
                pend_d      = 1'b0;
                case ({half_val, half_bit})
                    2'b00:   sym_d.kind = SYM_ZERO;
                    2'b11:   sym_d.kind = SYM_ONE;
                    2'b01:   sym_d.kind = SYM_FLOAT;
                    default: sym_d.kind = SYM_BAD;      // 1 then 0 is illegal
                endcase
            end
        end else if (sync_hit && have_high) begin
            sym_d.valid = 1'b1;
            pend_d      = 1'b0;
            sym_d.kind  = (is_short(high_w) && !half_pend) ? SYM_SYNC : SYM_BAD;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            have_high <= 1'b0;
            half_pend <= 1'b0;
            half_val  <= 1'b0;
            sym_o     <= '0;
        end else begin
            if (fall) have_high <= 1'b1;
            half_pend <= pend_d;
            half_val  <= val_d;
            sym_o     <= sym_d;     // Strobe one cycle after the deciding edge
        end
    end

endmodule

// File: pt2272_pkg.sv
`include "pt2272_macros.svh"

package pt2272_pkg;

    // Trit codes as stored in the frame word, 2'b01 never appears
    typedef enum logic [1:0] {
        TRIT_ZERO  = 2'b00,
        TRIT_FLOAT = 2'b10,
        TRIT_ONE   = 2'b11
    } pt_trit_e;

    // What the detector saw on the line
    typedef enum logic [2:0] {
        SYM_ZERO,
        SYM_ONE,
        SYM_FLOAT,
        SYM_SYNC,
        SYM_BAD     // Width out of range or illegal half pair
    } pt_sym_kind_e;

    typedef struct packed {
        logic         valid;    // One cycle strobe
        pt_sym_kind_e kind;
    } pt_symbol_t;

    typedef pt_trit_e [`PT_ADDR_TRITS-1:0] pt_addr_t;  // Top trit received first
    typedef pt_trit_e [`PT_DATA_TRITS-1:0] pt_data_t;

    typedef struct packed {
        pt_addr_t addr;     // Upper 16 bits
        pt_data_t data;     // Lower 8 bits
    } pt_fields_t;

    // Same 24 bits, trit view while shifting and field view while checking
    typedef union packed {
        pt_trit_e [`PT_FRAME_TRITS-1:0] trits;
        pt_fields_t                     fields;
    } pt_frame_u;

    typedef struct packed {
        logic      valid;   // One cycle strobe
        pt_frame_u word;
    } pt_frame_t;

endpackage

// File: pt2272_macros.svh
`ifndef PT2272_MACROS_SVH
`define PT2272_MACROS_SVH

// Pulse width windows in clk cycles, both ends inclusive
`define PT_SHORT_MIN 6      // Nominal short pulse is 16 cycles
`define PT_SHORT_MAX 20
`define PT_LONG_MIN 36      // Nominal long pulse is 48 cycles
`define PT_LONG_MAX 60

// A low this long after a short high closes the frame
`define PT_SYNC_MIN 256

`define PT_CNT_W 9          // Width counters, must hold PT_SYNC_MIN

// Frame layout in trits
`define PT_ADDR_TRITS 8
`define PT_DATA_TRITS 4
`define PT_FRAME_TRITS 12   // Address plus data

`endif
